//--- baser_rx_pkg.sv
// 10GBASE-R receiver shared constants, block encodings and state types
package baser_rx_pkg;

    // datapath geometry
    localparam int DATA_W = 64;
    localparam int KEEP_W = 8;
    localparam int HDR_W = 2;

    // legal sync headers
    typedef enum logic [1:0] {
        SYNC_DATA = 2'b10,
        SYNC_CTRL = 2'b01
    } sync_e;

    // control block type field, lane 0 byte of a control block
    typedef enum logic [7:0] {
        BLOCK_TYPE_CTRL     = 8'h1e,
        BLOCK_TYPE_OS_4     = 8'h2d,
        BLOCK_TYPE_START_4  = 8'h33,
        BLOCK_TYPE_OS_START = 8'h66,
        BLOCK_TYPE_OS_04    = 8'h55,
        BLOCK_TYPE_START_0  = 8'h78,
        BLOCK_TYPE_OS_0     = 8'h4b,
        // terminate, n data bytes ahead of the T character
        BLOCK_TYPE_TERM_0   = 8'h87,
        BLOCK_TYPE_TERM_1   = 8'h99,
        BLOCK_TYPE_TERM_2   = 8'haa,
        BLOCK_TYPE_TERM_3   = 8'hb4,
        BLOCK_TYPE_TERM_4   = 8'hcc,
        BLOCK_TYPE_TERM_5   = 8'hd2,
        BLOCK_TYPE_TERM_6   = 8'he1,
        BLOCK_TYPE_TERM_7   = 8'hff
    } block_type_e;

    // meaning of a decoded block for the later stages
    typedef enum logic [2:0] {
        KIND_IDLE,
        KIND_START,
        KIND_DATA,
        KIND_TERM,
        KIND_ERROR
    } blk_kind_e;

    // framer FSM
    typedef enum logic [1:0] {
        IDLE,
        PAYLOAD,
        LAST
    } frame_state_e;

    // preamble bytes after the start character
    localparam logic [7:0] ETH_PRE = 8'h55;
    localparam logic [7:0] ETH_SFD = 8'hd5;

    // reflected 802.3 polynomial
    localparam logic [31:0] CRC_POLY = 32'hedb88320;

    // register contents after data plus a correct FCS
    localparam logic [31:0] CRC_RESIDUE = 32'hdebb20e3;

endpackage

//--- baser_rx_block_decode.sv
// 10GBASE-R block decoder, classifies each 66-bit block and tracks frame boundaries
module baser_rx_block_decode
    import baser_rx_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [DATA_W-1:0] rx_data,
    input  logic [HDR_W-1:0]  rx_hdr,
    output blk_kind_e         dec_kind,
    output logic [DATA_W-1:0] dec_data,
    output logic [KEEP_W-1:0] dec_keep,
    output logic              dec_preamble_ok,
    output logic              stat_err_bad_block
);

    logic              in_frame;
    logic              is_data;
    logic              is_ctrl;
    logic              type_ok;
    logic              type_start;
    logic              type_term;
    logic              is_start;
    logic              is_term;
    logic [2:0]        term_lane;
    logic [DATA_W-1:0] term_data;
    logic [KEEP_W-1:0] term_keep;
    logic              preamble_ok;
    blk_kind_e         kind_next;
    logic [DATA_W-1:0] data_next;
    logic [KEEP_W-1:0] keep_next;

    assign is_data = rx_hdr == SYNC_DATA;
    assign is_ctrl = rx_hdr == SYNC_CTRL;

    // block type legality, only meaningful with a control header
    always_comb begin
        type_ok = 1'b1;
        type_start = 1'b0;
        type_term = 1'b0;
        case (rx_data[7:0])
            BLOCK_TYPE_START_0: type_start = 1'b1;
            BLOCK_TYPE_TERM_0, BLOCK_TYPE_TERM_1, BLOCK_TYPE_TERM_2, BLOCK_TYPE_TERM_3,
            BLOCK_TYPE_TERM_4, BLOCK_TYPE_TERM_5, BLOCK_TYPE_TERM_6, BLOCK_TYPE_TERM_7:
                type_term = 1'b1;
            // legal, but not a frame boundary we keep
            BLOCK_TYPE_CTRL, BLOCK_TYPE_OS_4, BLOCK_TYPE_START_4,
            BLOCK_TYPE_OS_START, BLOCK_TYPE_OS_04, BLOCK_TYPE_OS_0:
                type_ok = 1'b1;
            default: type_ok = 1'b0;
        endcase
    end

    always_comb begin
        case (rx_data[7:0])
            BLOCK_TYPE_TERM_1: term_lane = 3'd1;
            BLOCK_TYPE_TERM_2: term_lane = 3'd2;
            BLOCK_TYPE_TERM_3: term_lane = 3'd3;
            BLOCK_TYPE_TERM_4: term_lane = 3'd4;
            BLOCK_TYPE_TERM_5: term_lane = 3'd5;
            BLOCK_TYPE_TERM_6: term_lane = 3'd6;
            BLOCK_TYPE_TERM_7: term_lane = 3'd7;
            default: term_lane = 3'd0;
        endcase
    end

    assign is_start = is_ctrl && type_start;
    assign is_term = is_ctrl && type_term;

    // terminate data sits in bytes 1 up, move it down to byte 0
    assign term_data = (rx_data >> 8) & ~({DATA_W{1'b1}} << (8 * term_lane));
    assign term_keep = ~({KEEP_W{1'b1}} << term_lane);

    assign preamble_ok = rx_data[55:8] == {6{ETH_PRE}} && rx_data[63:56] == ETH_SFD;

    always_comb begin
        if (!in_frame) begin
            kind_next = is_start ? KIND_START : KIND_IDLE;
        end else if (is_data) begin
            kind_next = KIND_DATA;
        end else if (is_term) begin
            kind_next = KIND_TERM;
        end else begin
            // idle, ordered set, second start or a bad block inside a frame
            kind_next = KIND_ERROR;
        end
    end

    always_comb begin
        keep_next = '0;
        data_next = rx_data;
        if (kind_next == KIND_DATA) begin
            keep_next = '1;
        end else if (kind_next == KIND_TERM) begin
            keep_next = term_keep;
            data_next = term_data;
        end
    end

    always_ff @(posedge clk) begin
        dec_data <= data_next;
        dec_keep <= keep_next;
        dec_preamble_ok <= preamble_ok;

        if (rst) begin
            in_frame <= 1'b0;
            dec_kind <= KIND_IDLE;
            stat_err_bad_block <= 1'b0;
        end else begin
            dec_kind <= kind_next;
            stat_err_bad_block <= !(is_data || (is_ctrl && type_ok));
            // any non-data block closes the frame, a start reopens it
            if (!is_data) begin
                in_frame <= is_start;
            end
        end
    end

endmodule

//--- baser_rx_crc.sv
// 10GBASE-R receive CRC stage, runs the Ethernet CRC-32 over the valid bytes of each beat
module baser_rx_crc
    import baser_rx_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  blk_kind_e         dec_kind,
    input  logic [DATA_W-1:0] dec_data,
    input  logic [KEEP_W-1:0] dec_keep,
    input  logic              dec_preamble_ok,
    output blk_kind_e         crc_kind,
    output logic [DATA_W-1:0] crc_data,
    output logic [KEEP_W-1:0] crc_keep,
    output logic              crc_preamble_ok,
    output logic              crc_ok
);

    logic [31:0] crc_reg;
    logic [31:0] crc_next;

    // one byte through the reflected LFSR, lsb first
    function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] din);
        logic [31:0] c;
        c = crc ^ {24'd0, din};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    // keep is contiguous from byte 0, so a running chain is enough
    always_comb begin
        crc_next = crc_reg;
        for (int n = 0; n < KEEP_W; n++) begin
            if (dec_keep[n]) begin
                crc_next = crc_byte(crc_next, dec_data[8*n +: 8]);
            end
        end
    end

    always_ff @(posedge clk) begin
        crc_data <= dec_data;
        crc_keep <= dec_keep;
        crc_preamble_ok <= dec_preamble_ok;

        if (rst) begin
            crc_reg <= '1;
            crc_kind <= KIND_IDLE;
            crc_ok <= 1'b0;
        end else begin
            crc_kind <= dec_kind;
            crc_ok <= dec_kind == KIND_TERM && crc_next == CRC_RESIDUE;
            if (dec_kind == KIND_START) begin
                crc_reg <= '1;
            end else begin
                crc_reg <= crc_next;
            end
        end
    end

endmodule

//--- baser_rx_framer.sv
// 10GBASE-R receive framer, builds output beats and reports per-frame status
module baser_rx_framer
    import baser_rx_pkg::*;
#(
    parameter int LEN_W = 16
) (
    input  logic              clk,
    input  logic              rst,
    input  blk_kind_e         crc_kind,
    input  logic [DATA_W-1:0] crc_data,
    input  logic [KEEP_W-1:0] crc_keep,
    input  logic              crc_preamble_ok,
    input  logic              crc_ok,
    input  logic              cfg_rx_enable,
    input  logic [LEN_W-1:0]  cfg_rx_max_pkt_len,
    output logic [DATA_W-1:0] m_tdata,
    output logic [KEEP_W-1:0] m_tkeep,
    output logic              m_tvalid,
    output logic              m_tlast,
    output logic              m_tuser,
    output logic              stat_pkt_good,
    output logic              stat_pkt_bad,
    output logic              stat_err_bad_fcs,
    output logic              stat_err_oversize,
    output logic              stat_err_framing,
    output logic              stat_err_preamble,
    output logic [LEN_W-1:0]  stat_pkt_len
);

    frame_state_e      state;
    frame_state_e      state_next;
    logic [DATA_W-1:0] hold_data;
    logic [KEEP_W-1:0] hold_keep;
    logic              hold_valid;
    logic              pre_ok;
    logic              term_ok;
    logic [LEN_W-1:0]  len_reg;
    logic [LEN_W-1:0]  len_next;
    logic [LEN_W:0]    len_sum;
    logic [3:0]        beat_bytes;

    logic              emit;
    logic              emit_last;
    logic              load_hold;
    logic              close;
    logic              close_framing;
    logic              close_fcs_ok;
    logic [LEN_W-1:0]  close_len;
    logic              close_oversize;
    logic              close_bad;

    // saturating byte count
    assign beat_bytes = 4'($countones(crc_keep));
    assign len_sum = {1'b0, len_reg} + (LEN_W + 1)'(beat_bytes);
    assign len_next = len_sum[LEN_W] ? '1 : len_sum[LEN_W-1:0];

    always_comb begin
        state_next = state;
        emit = 1'b0;
        emit_last = 1'b0;
        load_hold = 1'b0;
        close = 1'b0;
        close_framing = 1'b0;
        close_fcs_ok = 1'b1;
        close_len = len_next;
        case (state)
            IDLE: begin
                if (crc_kind == KIND_START && cfg_rx_enable) begin
                    state_next = PAYLOAD;
                end
            end
            PAYLOAD: begin
                emit = hold_valid;
                case (crc_kind)
                    KIND_DATA: load_hold = 1'b1;
                    KIND_TERM: begin
                        if (crc_keep == '0) begin
                            // lane 0 terminate, held beat is the last one
                            emit_last = 1'b1;
                            close = 1'b1;
                            close_fcs_ok = crc_ok;
                            state_next = IDLE;
                        end else begin
                            load_hold = 1'b1;
                            state_next = LAST;
                        end
                    end
                    default: begin
                        emit_last = 1'b1;
                        close = 1'b1;
                        close_framing = 1'b1;
                        state_next = IDLE;
                    end
                endcase
            end
            LAST: begin
                // partial terminate beat, anything arriving now is dropped
                emit = hold_valid;
                emit_last = 1'b1;
                close = 1'b1;
                close_fcs_ok = term_ok;
                close_len = len_reg;
                state_next = IDLE;
            end
            default: state_next = IDLE;
        endcase
    end

    assign close_oversize = close_len > cfg_rx_max_pkt_len;
    assign close_bad = close_framing || !close_fcs_ok || close_oversize;

    always_ff @(posedge clk) begin
        m_tdata <= hold_data;
        m_tkeep <= hold_keep;
        term_ok <= crc_ok;
        if (load_hold) begin
            hold_data <= crc_data;
            hold_keep <= crc_keep;
        end
        if (state == IDLE) begin
            len_reg <= '0;
            pre_ok <= crc_preamble_ok;
        end else begin
            len_reg <= len_next;
        end

        if (rst) begin
            state <= IDLE;
            hold_valid <= 1'b0;
            m_tvalid <= 1'b0;
            m_tlast <= 1'b0;
            m_tuser <= 1'b0;
            stat_pkt_good <= 1'b0;
            stat_pkt_bad <= 1'b0;
            stat_err_bad_fcs <= 1'b0;
            stat_err_oversize <= 1'b0;
            stat_err_framing <= 1'b0;
            stat_err_preamble <= 1'b0;
            stat_pkt_len <= '0;
        end else begin
            state <= state_next;
            // every payload cycle either refills or drains the hold slot
            hold_valid <= load_hold;
            m_tvalid <= emit;
            m_tlast <= emit && emit_last;
            m_tuser <= emit && emit_last && close_bad;
            stat_pkt_good <= close && !close_bad;
            stat_pkt_bad <= close && close_bad;
            stat_err_bad_fcs <= close && !close_fcs_ok;
            stat_err_oversize <= close && close_oversize;
            stat_err_framing <= close && close_framing;
            stat_err_preamble <= close && !pre_ok;
            stat_pkt_len <= close ? close_len : '0;
        end
    end

endmodule

//--- baser_rx_top.sv
// 10GBASE-R frame receiver top, chains block decode, CRC check and framer
module baser_rx_top
    import baser_rx_pkg::*;
#(
    parameter int LEN_W = 16
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [DATA_W-1:0] rx_data,
    input  logic [HDR_W-1:0]  rx_hdr,
    input  logic              cfg_rx_enable,
    input  logic [LEN_W-1:0]  cfg_rx_max_pkt_len,
    output logic [DATA_W-1:0] m_tdata,
    output logic [KEEP_W-1:0] m_tkeep,
    output logic              m_tvalid,
    output logic              m_tlast,
    output logic              m_tuser,
    output logic              stat_pkt_good,
    output logic              stat_pkt_bad,
    output logic              stat_err_bad_fcs,
    output logic              stat_err_oversize,
    output logic              stat_err_framing,
    output logic              stat_err_preamble,
    output logic              stat_err_bad_block,
    output logic [LEN_W-1:0]  stat_pkt_len
);

    blk_kind_e         dec_kind;
    logic [DATA_W-1:0] dec_data;
    logic [KEEP_W-1:0] dec_keep;
    logic              dec_preamble_ok;

    blk_kind_e         crc_kind;
    logic [DATA_W-1:0] crc_data;
    logic [KEEP_W-1:0] crc_keep;
    logic              crc_preamble_ok;
    logic              crc_ok;

    baser_rx_block_decode u_decode (
        .clk                (clk),
        .rst                (rst),
        .rx_data            (rx_data),
        .rx_hdr             (rx_hdr),
        .dec_kind           (dec_kind),
        .dec_data           (dec_data),
        .dec_keep           (dec_keep),
        .dec_preamble_ok    (dec_preamble_ok),
        .stat_err_bad_block (stat_err_bad_block)
    );

    baser_rx_crc u_crc (
        .clk             (clk),
        .rst             (rst),
        .dec_kind        (dec_kind),
        .dec_data        (dec_data),
        .dec_keep        (dec_keep),
        .dec_preamble_ok (dec_preamble_ok),
        .crc_kind        (crc_kind),
        .crc_data        (crc_data),
        .crc_keep        (crc_keep),
        .crc_preamble_ok (crc_preamble_ok),
        .crc_ok          (crc_ok)
    );

    baser_rx_framer #(
        .LEN_W (LEN_W)
    ) u_framer (
        .clk                (clk),
        .rst                (rst),
        .crc_kind           (crc_kind),
        .crc_data           (crc_data),
        .crc_keep           (crc_keep),
        .crc_preamble_ok    (crc_preamble_ok),
        .crc_ok             (crc_ok),
        .cfg_rx_enable      (cfg_rx_enable),
        .cfg_rx_max_pkt_len (cfg_rx_max_pkt_len),
        .m_tdata            (m_tdata),
        .m_tkeep            (m_tkeep),
        .m_tvalid           (m_tvalid),
        .m_tlast            (m_tlast),
        .m_tuser            (m_tuser),
        .stat_pkt_good      (stat_pkt_good),
        .stat_pkt_bad       (stat_pkt_bad),
        .stat_err_bad_fcs   (stat_err_bad_fcs),
        .stat_err_oversize  (stat_err_oversize),
        .stat_err_framing   (stat_err_framing),
        .stat_err_preamble  (stat_err_preamble),
        .stat_pkt_len       (stat_pkt_len)
    );

endmodule

//--- tb_baser_rx.sv
// testbench for the 10GBASE-R frame receiver, checks output beats and frame status
module tb_baser_rx;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LEN_W = 16;
    localparam logic [1:0] HDR_DATA = 2'b10;
    localparam logic [1:0] HDR_CTRL = 2'b01;
    localparam logic [63:0] IDLE_BLOCK = 64'h1e;
    localparam logic [31:0] FCS_POLY = 32'hedb88320;
    localparam logic [15:0] MAX_LEN = 16'd1518;
    localparam int GAP = 2;
    localparam int DRAIN_MAX = 16;
    localparam int DRAIN_EXTRA = 6;
    localparam int NUM_TESTS = 6;

    typedef struct packed {
        logic [63:0] data;
        logic [7:0]  keep;
        logic        last;
        logic        user;
    } beat_t;

    typedef struct packed {
        logic        good;
        logic        bad;
        logic        bad_fcs;
        logic        oversize;
        logic        framing;
        logic        preamble;
        logic [15:0] len;
    } status_t;

    logic             clk;
    logic             rst;
    logic [63:0]      rx_data;
    logic [1:0]       rx_hdr;
    logic             cfg_rx_enable;
    logic [LEN_W-1:0] cfg_rx_max_pkt_len;
    logic [63:0]      m_tdata;
    logic [7:0]       m_tkeep;
    logic             m_tvalid;
    logic             m_tlast;
    logic             m_tuser;
    logic             stat_pkt_good;
    logic             stat_pkt_bad;
    logic             stat_err_bad_fcs;
    logic             stat_err_oversize;
    logic             stat_err_framing;
    logic             stat_err_preamble;
    logic             stat_err_bad_block;
    logic [LEN_W-1:0] stat_pkt_len;
    logic             any_stat;

    logic [31:0] lfsr = 32'h9ed3;
    logic [7:0]  frame_b[$];
    beat_t       beat_q[$];
    status_t     stat_q[$];
    int          bad_block_exp = 0;
    int          errors = 0;
    int          err_mark = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    baser_rx_top #(
        .LEN_W (LEN_W)
    ) i_dut (
        .clk                (clk),
        .rst                (rst),
        .rx_data            (rx_data),
        .rx_hdr             (rx_hdr),
        .cfg_rx_enable      (cfg_rx_enable),
        .cfg_rx_max_pkt_len (cfg_rx_max_pkt_len),
        .m_tdata            (m_tdata),
        .m_tkeep            (m_tkeep),
        .m_tvalid           (m_tvalid),
        .m_tlast            (m_tlast),
        .m_tuser            (m_tuser),
        .stat_pkt_good      (stat_pkt_good),
        .stat_pkt_bad       (stat_pkt_bad),
        .stat_err_bad_fcs   (stat_err_bad_fcs),
        .stat_err_oversize  (stat_err_oversize),
        .stat_err_framing   (stat_err_framing),
        .stat_err_preamble  (stat_err_preamble),
        .stat_err_bad_block (stat_err_bad_block),
        .stat_pkt_len       (stat_pkt_len)
    );

    assign any_stat = stat_pkt_good | stat_pkt_bad | stat_err_bad_fcs | stat_err_oversize
                    | stat_err_framing | stat_err_preamble;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // galois form, one step per random bit
    function automatic logic [7:0] rand_byte();
        logic [7:0] b;
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            b[i] = lfsr[0];
        end
        return b;
    endfunction

    // bit serial, lsb first
    function automatic logic [31:0] crc_update(input logic [31:0] crc, input logic [7:0] d);
        logic [31:0] c;
        logic        fb;
        c = crc;
        for (int b = 0; b < 8; b++) begin
            fb = c[0] ^ d[b];
            c = {1'b0, c[31:1]};
            if (fb) begin
                c = c ^ FCS_POLY;
            end
        end
        return c;
    endfunction

    function automatic logic [7:0] term_type(input int t);
        case (t)
            1: return 8'h99;
            2: return 8'haa;
            3: return 8'hb4;
            4: return 8'hcc;
            5: return 8'hd2;
            6: return 8'he1;
            7: return 8'hff;
            default: return 8'h87;
        endcase
    endfunction

    function automatic logic [63:0] keep_mask(input logic [7:0] keep);
        logic [63:0] m;
        for (int i = 0; i < 8; i++) begin
            m[8*i +: 8] = {8{keep[i]}};
        end
        return m;
    endfunction

    function automatic int frame_blocks(input int len);
        return 2 + len / 8 + GAP;
    endfunction

    function automatic int planned_blocks();
        int n;
        n = 2;
        for (int len = 64; len < 80; len++) begin
            n += frame_blocks(len);
        end
        n += frame_blocks(70) + frame_blocks(120) + frame_blocks(100) + 2 * frame_blocks(64);
        // framing frame, stray data block, three bad blocks
        n += frame_blocks(40) + 1 + GAP + 3 + GAP;
        n += NUM_TESTS * (DRAIN_MAX + DRAIN_EXTRA);
        return n;
    endfunction

    task automatic send_block(input logic [1:0] hdr, input logic [63:0] data);
        @(posedge clk);
        #1;
        rx_hdr = hdr;
        rx_data = data;
    endtask

    // random payload followed by its FCS
    task automatic make_frame(input int len);
        logic [31:0] crc;
        logic [7:0]  d;
        frame_b.delete();
        crc = 32'hffffffff;
        for (int i = 0; i < len - 4; i++) begin
            d = rand_byte();
            frame_b.push_back(d);
            crc = crc_update(crc, d);
        end
        crc = ~crc;
        for (int i = 0; i < 4; i++) begin
            frame_b.push_back(crc[8*i +: 8]);
        end
    endtask

    // cut swaps the terminate for an idle block, only for whole-block lengths
    task automatic send_frame(input bit pre_bad, input bit cut);
        logic [63:0] blk;
        int          pos;
        int          t;
        blk = {8'hd5, {6{8'h55}}, 8'h78};
        if (pre_bad) begin
            blk[31:24] = 8'h57;
        end
        send_block(HDR_CTRL, blk);
        pos = 0;
        while (frame_b.size() - pos >= 8) begin
            for (int i = 0; i < 8; i++) begin
                blk[8*i +: 8] = frame_b[pos + i];
            end
            send_block(HDR_DATA, blk);
            pos += 8;
        end
        t = frame_b.size() - pos;
        blk = '0;
        blk[7:0] = cut ? 8'h1e : term_type(t);
        for (int i = 0; i < t; i++) begin
            blk[8*(i+1) +: 8] = frame_b[pos + i];
        end
        send_block(HDR_CTRL, blk);
        repeat (GAP) begin
            send_block(HDR_CTRL, IDLE_BLOCK);
        end
    endtask

    task automatic expect_frame(input bit pre_bad, input bit bad_fcs, input bit oversize,
                                input bit framing);
        beat_t   b;
        status_t s;
        int      pos;
        int      n;
        logic    bad;
        bad = bad_fcs || oversize || framing;
        pos = 0;
        while (pos < frame_b.size()) begin
            n = (frame_b.size() - pos >= 8) ? 8 : frame_b.size() - pos;
            b = '0;
            for (int i = 0; i < n; i++) begin
                b.data[8*i +: 8] = frame_b[pos + i];
                b.keep[i] = 1'b1;
            end
            pos += n;
            b.last = pos == frame_b.size();
            b.user = b.last && bad;
            beat_q.push_back(b);
        end
        s.good = !bad;
        s.bad = bad;
        s.bad_fcs = bad_fcs;
        s.oversize = oversize;
        s.framing = framing;
        s.preamble = pre_bad;
        s.len = 16'(frame_b.size());
        stat_q.push_back(s);
    endtask

    task automatic run_frame(input int len, input bit pre_bad, input bit flip_fcs,
                             input bit oversize, input bit cut);
        make_frame(len);
        if (flip_fcs) begin
            frame_b[len - 1] = frame_b[len - 1] ^ 8'h10;
        end
        expect_frame(pre_bad, flip_fcs, oversize, cut);
        send_frame(pre_bad, cut);
    endtask

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp)
        else begin
            $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_beat();
        beat_t e;
        assert (beat_q.size() > 0)
        else begin
            $display("t=%0t: output beat arrived while no beat was expected", $time);
            errors++;
        end
        if (beat_q.size() > 0) begin
            e = beat_q.pop_front();
            compare("m_tkeep", 64'(m_tkeep), 64'(e.keep));
            compare("m_tdata", m_tdata & keep_mask(e.keep), e.data);
            compare("m_tlast", 64'(m_tlast), 64'(e.last));
            compare("m_tuser", 64'(m_tuser), 64'(e.user));
        end
    endtask

    task automatic check_status();
        status_t e;
        assert (stat_q.size() > 0)
        else begin
            $display("t=%0t: frame status pulsed while no frame end was expected", $time);
            errors++;
        end
        if (stat_q.size() > 0) begin
            e = stat_q.pop_front();
            compare("stat_pkt_good", 64'(stat_pkt_good), 64'(e.good));
            compare("stat_pkt_bad", 64'(stat_pkt_bad), 64'(e.bad));
            compare("stat_err_bad_fcs", 64'(stat_err_bad_fcs), 64'(e.bad_fcs));
            compare("stat_err_oversize", 64'(stat_err_oversize), 64'(e.oversize));
            compare("stat_err_framing", 64'(stat_err_framing), 64'(e.framing));
            compare("stat_err_preamble", 64'(stat_err_preamble), 64'(e.preamble));
            compare("stat_pkt_len", 64'(stat_pkt_len), 64'(e.len));
        end
    endtask

    // outputs settle after the rising edge, so look at them on the falling one
    always @(negedge clk) begin
        if (!rst) begin
            if (m_tvalid) begin
                check_beat();
            end
            if (any_stat) begin
                check_status();
            end
            if (stat_err_bad_block) begin
                assert (bad_block_exp > 0)
                else begin
                    $display("t=%0t: bad block pulse with no bad block sent", $time);
                    errors++;
                end
                if (bad_block_exp > 0) begin
                    bad_block_exp--;
                end
            end
        end
    end

    last_with_status: assert property (@(posedge clk) disable iff (rst)
        m_tlast |-> (m_tvalid && (stat_pkt_good || stat_pkt_bad)))
    else begin
        $display("t=%0t: m_tlast without a valid beat and a frame status pulse", $time);
        errors++;
    end

    user_only_on_last: assert property (@(posedge clk) disable iff (rst) m_tuser |-> m_tlast)
    else begin
        $display("t=%0t: m_tuser high on a beat that is not the last", $time);
        errors++;
    end

    // idle until every expected output has shown up, then a few more blocks
    task automatic end_test(input string name);
        int n;
        n = 0;
        while ((beat_q.size() > 0 || stat_q.size() > 0 || bad_block_exp > 0) && n < DRAIN_MAX) begin
            send_block(HDR_CTRL, IDLE_BLOCK);
            n++;
        end
        repeat (DRAIN_EXTRA) begin
            send_block(HDR_CTRL, IDLE_BLOCK);
        end
        assert (beat_q.size() == 0 && stat_q.size() == 0 && bad_block_exp == 0)
        else begin
            $display("%s: %0d beats, %0d frame ends and %0d bad block pulses never appeared",
                     name, beat_q.size(), stat_q.size(), bad_block_exp);
            errors++;
        end
        beat_q.delete();
        stat_q.delete();
        bad_block_exp = 0;
        tests_run++;
        if (errors == err_mark) begin
            $display("test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: fail, %0d errors", tests_run, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        int limit_ns;
        limit_ns = 2 * planned_blocks() * 10 + 1000;
        #(limit_ns);
        $display("watchdog: run did not finish within %0d ns", limit_ns);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        rx_hdr = HDR_CTRL;
        rx_data = IDLE_BLOCK;
        cfg_rx_enable = 1'b1;
        cfg_rx_max_pkt_len = MAX_LEN;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int len = 64; len < 80; len++) begin
            run_frame(len, 1'b0, 1'b0, 1'b0, 1'b0);
        end
        end_test("good frames 64 to 79 bytes");

        run_frame(70, 1'b0, 1'b1, 1'b0, 1'b0);
        end_test("flipped FCS bit");

        cfg_rx_max_pkt_len = 16'd100;
        run_frame(120, 1'b0, 1'b0, 1'b1, 1'b0);
        run_frame(100, 1'b0, 1'b0, 1'b0, 1'b0);
        end_test("length limit 100");
        cfg_rx_max_pkt_len = MAX_LEN;

        run_frame(40, 1'b0, 1'b0, 1'b0, 1'b1);
        // data outside a frame is ignored
        send_block(HDR_DATA, 64'h0123_4567_89ab_cdef);
        repeat (GAP) begin
            send_block(HDR_CTRL, IDLE_BLOCK);
        end
        end_test("idle inside frame");

        bad_block_exp += 3;
        send_block(2'b00, IDLE_BLOCK);
        send_block(2'b11, IDLE_BLOCK);
        send_block(HDR_CTRL, 64'h0);
        repeat (GAP) begin
            send_block(HDR_CTRL, IDLE_BLOCK);
        end
        run_frame(64, 1'b1, 1'b0, 1'b0, 1'b0);
        end_test("bad blocks and preamble");

        cfg_rx_enable = 1'b0;
        make_frame(64);
        send_frame(1'b0, 1'b0);
        end_test("receive disabled");
        cfg_rx_enable = 1'b1;

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- baser_rx.f
baser_rx_pkg.sv
baser_rx_block_decode.sv
baser_rx_crc.sv
baser_rx_framer.sv
baser_rx_top.sv
tb_baser_rx.sv

//--- run_sim.sh
#!/bin/sh
# build and run the receiver testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
    --top-module tb_baser_rx \
    -f baser_rx.f \
    -o sim_baser_rx

./obj_dir/sim_baser_rx | tee sim.log

if grep -q "TB FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

echo "simulation finished without failure"
exit 0
